// File: filelist.f
+incdir+.
xbar_pkg.sv
entry_select.sv
ch_req_buffer.sv
bank_rr_arbiter.sv
xbar_top.sv
tb_xbar.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_xbar
	./obj_dir/Vtb_xbar | tee /dev/stderr | grep -F "Everything OK" > /dev/null

clean:
	rm -rf obj_dir

// File: tb_xbar_table.svh
`ifndef TB_XBAR_TABLE_SVH
`define TB_XBAR_TABLE_SVH

// each row holds valid, bank of ch0, ch1 and ch2, expected allow-in and expected bank_grant_o
// outputs are sampled mid-cycle before the row's own inputs are taken
task automatic fill_table;
  // reset state
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b111, 12'h000);
  // single request from ch1 to bank 2
  add_row(3'b010, 2'd0, 2'd2, 2'd0, 3'b111, 12'h000);
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b111, 12'h080);
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b111, 12'h000);
  // three channels to three banks at once
  add_row(3'b111, 2'd1, 2'd3, 2'd0, 3'b111, 12'h000);
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b111, 12'h40c);
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b111, 12'h000);
  // two bursts from all channels to bank 0
  add_row(3'b111, 2'd0, 2'd0, 2'd0, 3'b111, 12'h000);
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b111, 12'h001);
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b111, 12'h002);
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b111, 12'h004);
  add_row(3'b111, 2'd0, 2'd0, 2'd0, 3'b111, 12'h000);
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b111, 12'h001);
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b111, 12'h002);
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b111, 12'h004);
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b111, 12'h000);
  // flood of bank 3 from every channel
  add_row(3'b111, 2'd3, 2'd3, 2'd3, 3'b111, 12'h000);
  add_row(3'b111, 2'd3, 2'd3, 2'd3, 3'b111, 12'h800);
  add_row(3'b111, 2'd3, 2'd3, 2'd3, 3'b111, 12'h200);
  add_row(3'b111, 2'd3, 2'd3, 2'd3, 3'b111, 12'h400);
  add_row(3'b111, 2'd3, 2'd3, 2'd3, 3'b111, 12'h800);
  add_row(3'b111, 2'd3, 2'd3, 2'd3, 3'b111, 12'h200);
  // ch0 and ch1 full so their requests here are dropped
  add_row(3'b111, 2'd3, 2'd3, 2'd3, 3'b100, 12'h400);
  // drain
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b001, 12'h800);
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b011, 12'h200);
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b111, 12'h400);
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b111, 12'h800);
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b111, 12'h200);
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b111, 12'h400);
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b111, 12'h800);
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b111, 12'h200);
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b111, 12'h400);
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b111, 12'h800);
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b111, 12'h200);
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b111, 12'h400);
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b111, 12'h800);
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b111, 12'h000);
  add_row(3'b000, 2'd0, 2'd0, 2'd0, 3'b111, 12'h000);
endtask

`endif

// File: tb_xbar.sv
`timescale 1ns/1ns
`include "xbar_defines.svh"

module tb_xbar;

  localparam int NUM_ROWS    = 38;
  localparam int RAND_CYCLES = 200;
  localparam int CYCLE_LIMIT = NUM_ROWS + RAND_CYCLES + 100;
  localparam int GRANT_W     = `XBAR_NUM_BANK * `XBAR_NUM_CH;

  logic                 clk;
  logic                 rst;
  xbar_pkg::ch_vec_t    ch_valid;
  xbar_pkg::line_addr_t ch0_addr;
  xbar_pkg::line_addr_t ch1_addr;
  xbar_pkg::line_addr_t ch2_addr;
  xbar_pkg::ch_vec_t    allow_in;
  logic [GRANT_W-1:0]   bank_grant;

  // directed rows
  xbar_pkg::ch_vec_t    tbl_valid [NUM_ROWS];
  xbar_pkg::bank_id_t   tbl_bank  [NUM_ROWS][`XBAR_NUM_CH];
  xbar_pkg::ch_vec_t    tbl_allow [NUM_ROWS];
  logic [GRANT_W-1:0]   tbl_grant [NUM_ROWS];
  int                   fill_idx = 0;

  // accepted but not yet granted per channel and bank
  int outstanding [`XBAR_NUM_CH][`XBAR_NUM_BANK];

  integer seed;
  int     cycle_cnt    = 0;
  int     table_errors = 0;
  int     rand_errors  = 0;
  int     checks       = 0;

  xbar_top UUT (
    .clk_i         (clk),
    .rst_i         (rst),
    .ch_valid_i    (ch_valid),
    .ch0_addr_i    (ch0_addr),
    .ch1_addr_i    (ch1_addr),
    .ch2_addr_i    (ch2_addr),
    .ch_allow_in_o (allow_in),
    .bank_grant_o  (bank_grant)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("run timed out after %0d cycles", cycle_cnt);
      $display("Something failed");
      $finish;
    end
  end

  task automatic add_row(input xbar_pkg::ch_vec_t vld, input xbar_pkg::bank_id_t b0, b1, b2,
                         input xbar_pkg::ch_vec_t allow, input logic [GRANT_W-1:0] grant);
    tbl_valid[fill_idx]    = vld;
    tbl_bank[fill_idx][0]  = b0;
    tbl_bank[fill_idx][1]  = b1;
    tbl_bank[fill_idx][2]  = b2;
    tbl_allow[fill_idx]    = allow;
    tbl_grant[fill_idx]    = grant;
    fill_idx++;
  endtask

  `include "tb_xbar_table.svh"

  // bank in bits 8:7 with the other bits random
  function automatic xbar_pkg::line_addr_t build_addr(input xbar_pkg::bank_id_t bank);
    xbar_pkg::line_addr_t a;
    a = xbar_pkg::line_addr_t'($random(seed));
    a[`XBAR_BANK_LSB +: 2] = bank;
    return a;
  endfunction

  task automatic drive_inputs(input xbar_pkg::ch_vec_t vld, input xbar_pkg::bank_id_t b0, b1, b2);
    ch_valid <= vld;
    ch0_addr <= build_addr(b0);
    ch1_addr <= build_addr(b1);
    ch2_addr <= build_addr(b2);
  endtask

  // --------------------------------------------------
  // scoreboard for the random phase
  // --------------------------------------------------
  task automatic check_grants;
    xbar_pkg::ch_vec_t g;
    for (int b = 0; b < `XBAR_NUM_BANK; b++) begin
      g = bank_grant[b*`XBAR_NUM_CH +: `XBAR_NUM_CH];
      checks++;
      if ($countones(g) > 1) begin
        $display("Fail at %0t: bank %0d grants several channels %b", $time, b, g);
        rand_errors++;
      end
      for (int c = 0; c < `XBAR_NUM_CH; c++) begin
        if (g[c]) begin
          if (outstanding[c][b] == 0) begin
            $display("Fail at %0t: grant bank %0d ch %0d with nothing pending", $time, b, c);
            rand_errors++;
          end else begin
            outstanding[c][b]--;
          end
        end
      end
    end
  endtask

  // allow-in is stable mid-cycle, so this is what the next edge takes
  task automatic record_accepts(input xbar_pkg::ch_vec_t vld, input xbar_pkg::bank_id_t b0, b1, b2);
    xbar_pkg::bank_id_t bk [`XBAR_NUM_CH];
    bk[0] = b0;
    bk[1] = b1;
    bk[2] = b2;
    for (int c = 0; c < `XBAR_NUM_CH; c++) begin
      if (vld[c] && allow_in[c]) begin
        outstanding[c][bk[c]]++;
      end
    end
  endtask

  function automatic int pending_total();
    int sum;
    sum = 0;
    for (int c = 0; c < `XBAR_NUM_CH; c++) begin
      for (int b = 0; b < `XBAR_NUM_BANK; b++) begin
        sum += outstanding[c][b];
      end
    end
    return sum;
  endfunction

  // --------------------------------------------------
  // test phases
  // --------------------------------------------------
  task automatic run_table;
    for (int r = 0; r < NUM_ROWS; r++) begin
      @(posedge clk);
      drive_inputs(tbl_valid[r], tbl_bank[r][0], tbl_bank[r][1], tbl_bank[r][2]);
      @(negedge clk);
      checks++;
      if (allow_in !== tbl_allow[r]) begin
        $display("Fail at %0t: row %0d allow-in %b, expected %b", $time, r, allow_in,
                 tbl_allow[r]);
        table_errors++;
      end
      checks++;
      if (bank_grant !== tbl_grant[r]) begin
        $display("Fail at %0t: row %0d bank_grant_o %h, expected %h", $time, r, bank_grant,
                 tbl_grant[r]);
        table_errors++;
      end
    end
  endtask

  task automatic run_random;
    xbar_pkg::ch_vec_t  vld;
    xbar_pkg::bank_id_t b0;
    xbar_pkg::bank_id_t b1;
    xbar_pkg::bank_id_t b2;
    for (int n = 0; n < RAND_CYCLES; n++) begin
      @(posedge clk);
      vld = xbar_pkg::ch_vec_t'($random(seed));
      b0  = xbar_pkg::bank_id_t'($random(seed));
      b1  = xbar_pkg::bank_id_t'($random(seed));
      b2  = xbar_pkg::bank_id_t'($random(seed));
      drive_inputs(vld, b0, b1, b2);
      @(negedge clk);
      check_grants();
      record_accepts(vld, b0, b1, b2);
    end
  endtask

  // idle until every accepted request has been served
  task automatic drain_idle;
    int left;
    @(posedge clk);
    drive_inputs('0, 2'd0, 2'd0, 2'd0);
    left = 1;
    while (left != 0) begin
      @(negedge clk);
      check_grants();
      left = pending_total();
    end
    repeat (5) begin
      @(negedge clk);
      check_grants();
    end
    checks++;
    if (allow_in !== 3'b111) begin
      $display("Fail at %0t: allow-in %b after drain, expected 111", $time, allow_in);
      rand_errors++;
    end
  endtask

  initial begin
    seed     = 32'hccf5_5d6d;
    rst      = 1'b1;
    ch_valid = '0;
    ch0_addr = '0;
    ch1_addr = '0;
    ch2_addr = '0;
    for (int c = 0; c < `XBAR_NUM_CH; c++) begin
      for (int b = 0; b < `XBAR_NUM_BANK; b++) begin
        outstanding[c][b] = 0;
      end
    end
    fill_table();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    run_table();
    run_random();
    drain_idle();
    $display("errors: table %0d, random %0d, out of %0d checks", table_errors, rand_errors,
             checks);
    if (table_errors + rand_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: xbar_top.sv
`timescale 1ns/1ns
`include "xbar_defines.svh"

module xbar_top (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  input  xbar_pkg::ch_vec_t                       ch_valid_i,
  input  xbar_pkg::line_addr_t                    ch0_addr_i,
  input  xbar_pkg::line_addr_t                    ch1_addr_i,
  input  xbar_pkg::line_addr_t                    ch2_addr_i,
  output xbar_pkg::ch_vec_t                       ch_allow_in_o,
  output logic [`XBAR_NUM_BANK*`XBAR_NUM_CH-1:0] bank_grant_o
);

  xbar_pkg::line_addr_t ch_addr     [`XBAR_NUM_CH];
  logic                 ch_allow    [`XBAR_NUM_CH];
  xbar_pkg::bank_vec_t  ch_bank_req [`XBAR_NUM_CH];
  xbar_pkg::bank_vec_t  ch_bank_gnt [`XBAR_NUM_CH];
  xbar_pkg::ch_vec_t    bank_ch_req [`XBAR_NUM_BANK];
  xbar_pkg::ch_vec_t    bank_ch_gnt [`XBAR_NUM_BANK];

  assign ch_addr[0] = ch0_addr_i;
  assign ch_addr[1] = ch1_addr_i;
  assign ch_addr[2] = ch2_addr_i;

  // --------------------------------------------------
  // channel request buffers
  // --------------------------------------------------
  for (genvar c = 0; c < `XBAR_NUM_CH; c++) begin : g_ch
    ch_req_buffer u_buf (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_valid_i (ch_valid_i[c]),
      .req_addr_i  (ch_addr[c]),
      .bank_gnt_i  (ch_bank_gnt[c]),
      .allow_in_o  (ch_allow[c]),
      .bank_req_o  (ch_bank_req[c])
    );
  end

  // --------------------------------------------------
  // bank arbiters
  // --------------------------------------------------
  for (genvar b = 0; b < `XBAR_NUM_BANK; b++) begin : g_bank
    bank_rr_arbiter u_arb (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .req_i   (bank_ch_req[b]),
      .grant_o (bank_ch_gnt[b])
    );
  end

  // channel-major requests to bank-major
  always_comb begin
    for (int b = 0; b < `XBAR_NUM_BANK; b++) begin
      for (int c = 0; c < `XBAR_NUM_CH; c++) begin
        bank_ch_req[b][c] = ch_bank_req[c][b];
      end
    end
  end

  // grants back to the channels, and out per bank
  always_comb begin
    for (int c = 0; c < `XBAR_NUM_CH; c++) begin
      ch_allow_in_o[c] = ch_allow[c];
      for (int b = 0; b < `XBAR_NUM_BANK; b++) begin
        ch_bank_gnt[c][b] = bank_ch_gnt[b][c];
      end
    end
    for (int b = 0; b < `XBAR_NUM_BANK; b++) begin
      bank_grant_o[b*`XBAR_NUM_CH +: `XBAR_NUM_CH] = bank_ch_gnt[b];
    end
  end

endmodule

// File: bank_rr_arbiter.sv
`timescale 1ns/1ns
`include "xbar_defines.svh"

module bank_rr_arbiter (
  input  logic              clk_i,
  input  logic              rst_i,
  input  xbar_pkg::ch_vec_t req_i,
  output xbar_pkg::ch_vec_t grant_o
);

  localparam int IDX_W = $clog2(`XBAR_NUM_CH);

  logic [IDX_W-1:0] last_q;
  logic [IDX_W-1:0] win_idx;

  // --------------------------------------------------
  // round-robin search
  // --------------------------------------------------
  // starts one past the last winner; the last winner itself
  // comes last. walking from lowest to highest priority lets
  // the final hit stand
  always_comb begin : rr_search
    int pos;
    grant_o = '0;
    win_idx = last_q;
    for (int i = `XBAR_NUM_CH; i >= 1; i--) begin
      pos = int'(last_q) + i;
      if (pos >= `XBAR_NUM_CH) begin
        pos = pos - `XBAR_NUM_CH;
      end
      if (req_i[pos]) begin
        grant_o      = '0;
        grant_o[pos] = 1'b1;
        win_idx      = IDX_W'(pos);
      end
    end
  end

  // --------------------------------------------------
  // last winner
  // --------------------------------------------------
  // reset to the top channel so channel 0 goes first
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      last_q <= IDX_W'(`XBAR_NUM_CH - 1);
    end else if (|grant_o) begin
      last_q <= win_idx;
    end
  end

endmodule

// File: ch_req_buffer.sv
`timescale 1ns/1ns
`include "xbar_defines.svh"

module ch_req_buffer (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  req_valid_i,
  input  xbar_pkg::line_addr_t  req_addr_i,
  input  xbar_pkg::bank_vec_t   bank_gnt_i,
  output logic                  allow_in_o,
  output xbar_pkg::bank_vec_t   bank_req_o
);

  xbar_pkg::entry_ptr_t wr_ptr_q;
  xbar_pkg::entry_ptr_t rd_ptr_q;
  xbar_pkg::entry_ptr_t count_q;
  logic                 accept;
  logic                 pop;
  xbar_pkg::bank_id_t   req_bank;
  xbar_pkg::bank_vec_t  head_busy;

  // per-bank waiting masks and the entry each bank would take
  xbar_pkg::entry_vec_t mask_q   [`XBAR_NUM_BANK];
  xbar_pkg::entry_vec_t mask_d   [`XBAR_NUM_BANK];
  xbar_pkg::entry_vec_t mask_set [`XBAR_NUM_BANK];
  xbar_pkg::entry_vec_t mask_clr [`XBAR_NUM_BANK];
  xbar_pkg::entry_ptr_t sel      [`XBAR_NUM_BANK];

  // next slot in the circular buffer
  function automatic xbar_pkg::entry_ptr_t ptr_inc(input xbar_pkg::entry_ptr_t p);
    xbar_pkg::entry_ptr_t nxt;
    if (p == xbar_pkg::entry_ptr_t'(`XBAR_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = p + 1'b1;
    end
    return nxt;
  endfunction

  // --------------------------------------------------
  // write side
  // --------------------------------------------------
  // taken only from registered occupancy
  assign allow_in_o = (count_q < xbar_pkg::entry_ptr_t'(`XBAR_DEPTH));
  assign accept     = req_valid_i & allow_in_o;

  // bank field of the line address
  assign req_bank = req_addr_i[`XBAR_BANK_LSB +: $bits(xbar_pkg::bank_id_t)];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
    end else if (accept) begin
      wr_ptr_q <= ptr_inc(wr_ptr_q);
    end
  end

  // --------------------------------------------------
  // read side
  // --------------------------------------------------
  // head slot is free once no bank still waits on it
  assign pop = (count_q != '0) & ~(|head_busy);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rd_ptr_q <= '0;
    end else if (pop) begin
      rd_ptr_q <= ptr_inc(rd_ptr_q);
    end
  end

  // occupancy
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (accept & ~pop) begin
      count_q <= count_q + 1'b1;
    end else if (~accept & pop) begin
      count_q <= count_q - 1'b1;
    end
  end

  // --------------------------------------------------
  // per-bank masks
  // --------------------------------------------------
  for (genvar b = 0; b < `XBAR_NUM_BANK; b++) begin : g_bank
    entry_select u_sel (
      .valid_i  (mask_q[b]),
      .rd_ptr_i (rd_ptr_q),
      .entry_o  (sel[b])
    );

    // new request lands at the write pointer
    assign mask_set[b] = (accept && req_bank == xbar_pkg::bank_id_t'(b))
                       ? xbar_pkg::entry_vec_t'(1) << wr_ptr_q
                       : '0;

    // granted entry leaves on the next edge
    assign mask_clr[b] = bank_gnt_i[b]
                       ? xbar_pkg::entry_vec_t'(1) << sel[b]
                       : '0;

    assign mask_d[b]     = (mask_q[b] & ~mask_clr[b]) | mask_set[b];
    assign bank_req_o[b] = |mask_q[b];
    assign head_busy[b]  = mask_q[b][rd_ptr_q];
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int b = 0; b < `XBAR_NUM_BANK; b++) begin
        mask_q[b] <= '0;
      end
    end else begin
      for (int b = 0; b < `XBAR_NUM_BANK; b++) begin
        mask_q[b] <= mask_d[b];
      end
    end
  end

endmodule

// File: entry_select.sv
`timescale 1ns/1ns
`include "xbar_defines.svh"

module entry_select (
  input  xbar_pkg::entry_vec_t valid_i,
  input  xbar_pkg::entry_ptr_t rd_ptr_i,
  output xbar_pkg::entry_ptr_t entry_o
);

  // --------------------------------------------------
  // oldest waiting entry, counting from the read pointer
  // --------------------------------------------------
  // the walk runs from the farthest slot back to the read
  // pointer itself, so the last hit is the oldest one
  always_comb begin : oldest_pick
    int pos;
    entry_o = '0;
    for (int i = `XBAR_DEPTH - 1; i >= 0; i--) begin
      pos = int'(rd_ptr_i) + i;
      // wrap through the last slot back to slot 0
      if (pos >= `XBAR_DEPTH) begin
        pos = pos - `XBAR_DEPTH;
      end
      if (valid_i[pos]) begin
        entry_o = xbar_pkg::entry_ptr_t'(pos);
      end
    end
  end

endmodule

// File: xbar_pkg.sv
`include "xbar_defines.svh"

package xbar_pkg;

  // one bit per buffer entry
  typedef logic [`XBAR_DEPTH-1:0] entry_vec_t;

  // entry index or occupancy count
  typedef logic [`XBAR_PTR_W-1:0] entry_ptr_t;

  // one bit per bank
  typedef logic [`XBAR_NUM_BANK-1:0] bank_vec_t;

  // one bit per channel
  typedef logic [`XBAR_NUM_CH-1:0] ch_vec_t;

  // bank number
  typedef logic [$clog2(`XBAR_NUM_BANK)-1:0] bank_id_t;

  // line address without the offset bits
  typedef logic [`XBAR_ADDR_MSB:`XBAR_ADDR_LSB] line_addr_t;

endpackage

// File: xbar_defines.svh
`ifndef XBAR_DEFINES_SVH
`define XBAR_DEFINES_SVH

// crossbar size
`define XBAR_NUM_CH   3
`define XBAR_NUM_BANK 4

// per-channel request buffer
`define XBAR_DEPTH    5
`define XBAR_PTR_W    3

// line address range carried by each request
`define XBAR_ADDR_MSB 31
`define XBAR_ADDR_LSB 4

// low bit of the two-bit bank select field
`define XBAR_BANK_LSB 7

`endif
